// ==== include/ice51_macros.svh ====
`ifndef ICE51_MACROS_SVH
`define ICE51_MACROS_SVH

//////////////////////////////////////////////////
// serial timing

// clock cycles per serial bit
`define ICE51_BAUD_DIV 104

//////////////////////////////////////////////////
// code space

`define ICE51_CODE_AW 7           // 128 code bytes, pc width too
`define ICE51_RESET_PC 3          // first fetch after load

//////////////////////////////////////////////////
// transmit port

`define ICE51_TX_ADDR 16'h0201    // movx @dptr target for the uart
`define ICE51_TX_CREDITS 1        // bytes uart_tx can hold

`endif

// ==== hdl/ice51_pkg.sv ====
`default_nettype none
`include "ice51_macros.svh"

package ice51_pkg;

   //////////////////////////////////////////////////
   // sequencer and opcodes

   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } seq_state_e;

   typedef enum logic [7:0] {
      OP_LJMP     = 8'h02,   // ljmp addr16
      OP_DEC_A    = 8'h14,   // dec a
      OP_ADD_AI   = 8'h24,   // add a,#imm
      OP_JZ       = 8'h60,   // jz rel
      OP_XRL_AI   = 8'h64,   // xrl a,#imm
      OP_JNZ      = 8'h70,   // jnz rel
      OP_MOV_AI   = 8'h74,   // mov a,#imm
      OP_SJMP     = 8'h80,   // sjmp rel
      OP_MOV_DPTR = 8'h90,   // mov dptr,#imm16
      OP_CLR_A    = 8'hE4,   // clr a
      OP_MOVX_DA  = 8'hF0    // movx @dptr,a
   } opcode_e;

   //////////////////////////////////////////////////
   // payloads

   typedef logic [7:0] code_byte_t;
   typedef logic [`ICE51_CODE_AW-1:0] code_addr_t;

   typedef struct packed {
      logic       valid;
      code_byte_t data;
   } rx_byte_t;

   typedef struct packed {
      logic       en;
      code_addr_t addr;
      code_byte_t data;
   } code_wr_t;

   // one-hot-ish step controls, sequencer to datapath
   typedef struct packed {
      logic latch_op;
      logic latch_op1;
      logic latch_op2;
      logic pc_inc;
      logic execute;
      logic addr_from_pc;
   } seq_ctrl_t;

   typedef struct packed {
      logic       valid;
      code_byte_t data;
   } tx_req_t;

endpackage

`default_nettype wire

// ==== hdl/baud_timer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ice51_macros.svh"

module baud_timer (
   input  wire logic i_clk,
   input  wire logic i_nrst,
   input  wire logic i_clear,
   output logic      o_half,
   output logic      o_full
);

   localparam int CNT_W = $clog2(`ICE51_BAUD_DIV);

   logic [CNT_W-1:0] cnt;

   // ticks are decoded straight off the count
   assign o_half = (cnt == CNT_W'(`ICE51_BAUD_DIV / 2 - 1));
   assign o_full = (cnt == CNT_W'(`ICE51_BAUD_DIV - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         cnt <= '0;
      end else if (i_clear || o_full) begin
         cnt <= '0;                      // restart each bit period
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx import ice51_pkg::*; (
   input  wire logic i_clk,
   input  wire logic i_nrst,
   input  wire logic i_rx,
   output rx_byte_t  o_byte
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e  state;
   logic       rx_meta;
   logic       rx_sync;
   logic [2:0] bit_cnt;
   code_byte_t shift;
   logic       half;
   logic       full;
   logic       stop_ok;
   logic       pend;
   logic       pend_full;

   //////////////////////////////////////////////////
   // line resync, idles high

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
      end
   end

   // held clear while idle, re-aligned at the start bit middle
   baud_timer u_bit_timer (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_clear ((state == RX_IDLE) || ((state == RX_START) && half)),
      .o_half  (half),
      .o_full  (full)
   );

   //////////////////////////////////////////////////
   // frame FSM

   assign stop_ok = (state == RX_STOP) && full && rx_sync;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= RX_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            RX_IDLE: begin
               bit_cnt <= '0;
               if (!rx_sync) state <= RX_START;      // falling edge seen
            end
            RX_START: if (half) state <= rx_sync ? RX_IDLE : RX_DATA;  // glitch filter
            RX_DATA: if (full) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) state <= RX_STOP;
            end
            default: if (full) state <= RX_IDLE;     // bad stop bit drops the byte
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if ((state == RX_DATA) && full) shift <= {rx_sync, shift[7:1]};   // lsb first
   end

   //////////////////////////////////////////////////
   // byte strobe, one bit after the stop sample

   baud_timer u_pend_timer (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_clear (!pend),
      .o_half  (),
      .o_full  (pend_full)
   );

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pend <= 1'b0;
      else if (stop_ok) pend <= 1'b1;
      else if (pend_full) pend <= 1'b0;
   end

   // receiver is already idle here so a back to back frame is caught
   assign o_byte = '{valid: pend && pend_full, data: shift};

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx import ice51_pkg::*; (
   input  wire logic    i_clk,
   input  wire logic    i_nrst,
   input  wire tx_req_t i_req,
   output logic         o_credit,
   output logic         o_tx
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e  state;
   logic [3:0] bit_cnt;     // start, 8 data, stop
   code_byte_t shift;
   logic       full;
   logic       last;

   baud_timer u_bit_timer (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_clear (state == TX_IDLE),
      .o_half  (),
      .o_full  (full)
   );

   assign last     = (bit_cnt == 4'd9);
   assign o_credit = (state == TX_SEND) && full && last;    // stop bit done, slot free

   //////////////////////////////////////////////////
   // frame FSM

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         bit_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               bit_cnt <= '0;
               if (i_req.valid) state <= TX_START;
            end
            TX_START: if (full) begin
               bit_cnt <= bit_cnt + 1'b1;
               state   <= TX_SEND;
            end
            default: if (full) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (last) state <= TX_IDLE;
            end
         endcase
      end
   end

   // ones shift in behind the data and form the stop bit
   always_ff @(posedge i_clk) begin
      if ((state == TX_IDLE) && i_req.valid) shift <= i_req.data;
      else if ((state == TX_SEND) && full) shift <= {1'b1, shift[7:1]};
   end

   always_comb begin
      case (state)
         TX_START: o_tx = 1'b0;
         TX_SEND:  o_tx = shift[0];
         default:  o_tx = 1'b1;          // line idles high
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/code_store.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ice51_macros.svh"

module code_store import ice51_pkg::*; (
   input  wire logic       i_clk,
   input  wire logic       i_nrst,
   input  wire rx_byte_t   i_rx,
   input  wire code_addr_t i_rd_addr,
   output code_byte_t      o_rd_data,
   output logic            o_load_done
);

   localparam int DEPTH = 1 << `ICE51_CODE_AW;

   code_byte_t mem [DEPTH];
   code_addr_t load_addr;
   code_wr_t   wr;

   // received bytes only land while loading
   assign wr = '{en: i_rx.valid && !o_load_done, addr: load_addr, data: i_rx.data};

   always_ff @(posedge i_clk) begin
      if (wr.en) mem[wr.addr] <= wr.data;
      o_rd_data <= mem[i_rd_addr];       // one cycle read
   end

   //////////////////////////////////////////////////
   // load counter

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_addr   <= '0;
         o_load_done <= 1'b0;
      end else if (wr.en) begin
         load_addr <= load_addr + 1'b1;              // wraps after the last byte
         if (load_addr == '1) o_load_done <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/cpu_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ice51_macros.svh"

module cpu_sequencer import ice51_pkg::*; (
   input  wire logic    i_clk,
   input  wire logic    i_nrst,
   input  wire logic    i_load_done,
   input  wire opcode_e i_op,
   input  wire logic    i_tx_hit,
   input  wire logic    i_credit,
   output seq_ctrl_t    o_ctrl
);

   localparam int CRED_W = $clog2(`ICE51_TX_CREDITS + 1);

   seq_state_e        state;
   seq_state_e        state_next;
   logic [1:0]        op_len;
   logic [CRED_W-1:0] credits;
   logic              stall;
   logic              take;

   // byte count, only looked at in DECODE0 where i_op is the fresh opcode
   always_comb begin
      case (i_op)
         OP_MOV_AI, OP_ADD_AI, OP_XRL_AI,
         OP_SJMP, OP_JZ, OP_JNZ:  op_len = 2'd2;
         OP_MOV_DPTR, OP_LJMP:    op_len = 2'd3;
         default:                 op_len = 2'd1;     // unknown runs as nop
      endcase
   end

   assign stall = i_tx_hit && (credits == '0);
   assign take  = o_ctrl.execute && i_tx_hit;

   //////////////////////////////////////////////////
   // state walk

   always_comb begin
      o_ctrl     = '0;
      state_next = state;
      case (state)
         FETCH: begin
            o_ctrl.addr_from_pc = 1'b1;
            o_ctrl.pc_inc       = i_load_done;   // parked until code is in
            if (i_load_done) state_next = DECODE0;
         end
         DECODE0: begin
            o_ctrl.latch_op     = 1'b1;
            o_ctrl.addr_from_pc = 1'b1;
            o_ctrl.pc_inc       = (op_len != 2'd1);
            case (op_len)
               2'd1:    state_next = EXECUTE;
               2'd2:    state_next = DECODE2;   // single operand lands in op2
               default: state_next = DECODE1;
            endcase
         end
         DECODE1: begin
            o_ctrl.latch_op1    = 1'b1;
            o_ctrl.addr_from_pc = 1'b1;
            o_ctrl.pc_inc       = 1'b1;
            state_next          = DECODE2;
         end
         DECODE2: begin
            o_ctrl.latch_op2 = 1'b1;
            state_next       = EXECUTE;
         end
         default: begin
            o_ctrl.execute = !stall;             // wait here for a free tx slot
            if (!stall) state_next = FETCH;
         end
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= FETCH;
      else state <= state_next;
   end

   //////////////////////////////////////////////////
   // transmit credits

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         credits <= CRED_W'(`ICE51_TX_CREDITS);
      end else if (i_credit && !take) begin
         credits <= credits + 1'b1;
      end else if (take && !i_credit) begin
         credits <= credits - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/cpu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ice51_macros.svh"

module cpu_datapath import ice51_pkg::*; (
   input  wire logic       i_clk,
   input  wire logic       i_nrst,
   input  wire seq_ctrl_t  i_ctrl,
   input  wire code_byte_t i_code,
   output code_addr_t      o_rd_addr,
   output opcode_e         o_op,
   output logic            o_tx_hit,
   output tx_req_t         o_tx_req
);

   code_addr_t  pc;
   code_addr_t  pc_next;
   code_addr_t  rd_addr_q;
   code_addr_t  target;
   opcode_e     op_q;
   logic        op_fresh;   // opcode byte sits on i_code
   code_byte_t  op1_q;      // high byte of a 16-bit operand
   code_byte_t  op2_q;      // last operand byte
   code_byte_t  acc;
   code_byte_t  acc_next;
   logic [15:0] dptr;
   logic        taken;

   //////////////////////////////////////////////////
   // code read address and operand capture

   // address holds between reads
   assign o_rd_addr = i_ctrl.addr_from_pc ? pc : rd_addr_q;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rd_addr_q <= '0;
      else rd_addr_q <= o_rd_addr;
   end

   // set for the cycle after a fetch that leaves FETCH
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         op_fresh <= 1'b0;
      end else begin
         op_fresh <= i_ctrl.addr_from_pc && i_ctrl.pc_inc && !i_ctrl.latch_op
                     && !i_ctrl.latch_op1;
      end
   end

   assign o_op = op_fresh ? opcode_e'(i_code) : op_q;   // sequencer needs it early

   always_ff @(posedge i_clk) begin
      if (i_ctrl.latch_op) op_q <= opcode_e'(i_code);
      if (i_ctrl.latch_op1) op1_q <= i_code;
      if (i_ctrl.latch_op2) op2_q <= i_code;
   end

   //////////////////////////////////////////////////
   // program counter

   // pc already points past the instruction at execute
   always_comb begin
      taken  = 1'b0;
      target = pc + code_addr_t'(op2_q);   // rel offset wraps at code width
      case (op_q)
         OP_SJMP: taken = 1'b1;
         OP_JZ:   taken = (acc == '0);
         OP_JNZ:  taken = (acc != '0);
         OP_LJMP: begin
            taken  = 1'b1;
            target = code_addr_t'(op2_q);     // upper address bits fall away
         end
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      if (i_ctrl.execute && taken) pc_next = target;
      else if (i_ctrl.pc_inc) pc_next = pc + 1'b1;
      else pc_next = pc;
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pc <= code_addr_t'(`ICE51_RESET_PC);
      else pc <= pc_next;
   end

   //////////////////////////////////////////////////
   // accumulator and dptr

   always_comb begin
      case (op_q)
         OP_MOV_AI: acc_next = op2_q;
         OP_ADD_AI: acc_next = acc + op2_q;     // no carry kept
         OP_XRL_AI: acc_next = acc ^ op2_q;
         OP_DEC_A:  acc_next = acc - 8'd1;
         OP_CLR_A:  acc_next = '0;
         default:   acc_next = acc;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc  <= '0;
         dptr <= '0;
      end else if (i_ctrl.execute) begin
         acc <= acc_next;
         if (op_q == OP_MOV_DPTR) dptr <= {op1_q, op2_q};
      end
   end

   //////////////////////////////////////////////////
   // transmit request

   // other movx targets have no memory behind them
   assign o_tx_hit = (op_q == OP_MOVX_DA) && (dptr == `ICE51_TX_ADDR);
   assign o_tx_req = '{valid: i_ctrl.execute && o_tx_hit, data: acc};

endmodule

`default_nettype wire

// ==== hdl/ice51_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ice51_top import ice51_pkg::*; (
   input  wire logic i_clk,
   input  wire logic i_nrst,
   input  wire logic i_uart_rx,
   output wire logic o_uart_tx
);

   rx_byte_t   rx_byte;
   code_addr_t rd_addr;
   code_byte_t rd_data;
   logic       load_done;
   seq_ctrl_t  ctrl;
   opcode_e    op;
   logic       tx_hit;
   tx_req_t    tx_req;
   logic       tx_credit;

   //////////////////////////////////////////////////
   // serial side

   uart_rx u_uart_rx (
      .i_clk  (i_clk),
      .i_nrst (i_nrst),
      .i_rx   (i_uart_rx),
      .o_byte (rx_byte)
   );

   uart_tx u_uart_tx (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_req    (tx_req),
      .o_credit (tx_credit),
      .o_tx     (o_uart_tx)
   );

   //////////////////////////////////////////////////
   // core

   code_store u_code_store (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (rx_byte),
      .i_rd_addr   (rd_addr),
      .o_rd_data   (rd_data),
      .o_load_done (load_done)
   );

   cpu_sequencer u_cpu_sequencer (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_op        (op),
      .i_tx_hit    (tx_hit),
      .i_credit    (tx_credit),
      .o_ctrl      (ctrl)
   );

   cpu_datapath u_cpu_datapath (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_ctrl    (ctrl),
      .i_code    (rd_data),
      .o_rd_addr (rd_addr),
      .o_op      (op),
      .o_tx_hit  (tx_hit),
      .o_tx_req  (tx_req)
   );

endmodule

`default_nettype wire

// ==== verification/ice51_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ice51_macros.svh"

module ice51_checker import ice51_pkg::*; (
   input  wire logic       i_clk,
   input  wire logic       i_tx,
   input  wire logic       i_loading,
   input  wire logic [7:0] i_test_id,
   input  wire code_byte_t i_image [128],
   output int              o_tests_done,
   output int              o_tests_failed
);

   localparam int BIT          = `ICE51_BAUD_DIV;
   localparam int LOAD_TIMEOUT = 140 * 10 * BIT;
   localparam int BYTE_TIMEOUT = 20 * 10 * BIT;
   localparam int QUIET_CYCLES = 3 * 10 * BIT;    // silence after the last byte
   localparam int STEP_LIMIT   = 4000;

   localparam int RX_OK      = 0;
   localparam int RX_TIMEOUT = 1;
   localparam int RX_FRAMING = 2;

   code_byte_t expect_q [$];

   //////////////////////////////////////////////////
   // reference instruction-set model

   function automatic void build_expected(input code_byte_t img [128]);
      code_addr_t  pc;
      code_addr_t  nxt;
      code_addr_t  tgt;
      code_byte_t  op;
      code_byte_t  b1;
      code_byte_t  b2;
      code_byte_t  acc;
      logic [15:0] dptr;
      int          len;
      int          steps;
      logic        stop;
      expect_q.delete();
      pc   = code_addr_t'(`ICE51_RESET_PC);
      acc  = 8'h00;
      dptr = 16'h0000;
      stop = 1'b0;
      steps = 0;
      while (!stop && steps < STEP_LIMIT) begin
         op = img[pc];
         b1 = img[code_addr_t'(pc + 1)];
         b2 = img[code_addr_t'(pc + 2)];
         case (op)
            OP_MOV_AI, OP_ADD_AI, OP_XRL_AI, OP_SJMP, OP_JZ, OP_JNZ: len = 2;
            OP_MOV_DPTR, OP_LJMP: len = 3;
            default: len = 1;
         endcase
         nxt = pc + code_addr_t'(len);
         // next instruction plus signed offset
         tgt = code_addr_t'(int'(nxt) + int'($signed(b1)));
         case (op)
            OP_MOV_AI:   acc = b1;
            OP_ADD_AI:   acc = acc + b1;
            OP_XRL_AI:   acc = acc ^ b1;
            OP_DEC_A:    acc = acc - 8'd1;
            OP_CLR_A:    acc = 8'h00;
            OP_MOV_DPTR: dptr = {b1, b2};
            OP_MOVX_DA: begin
               if (dptr == `ICE51_TX_ADDR) expect_q.push_back(acc);
            end
            OP_SJMP: begin
               if (tgt == pc) stop = 1'b1;     // self loop ends the program
               nxt = tgt;
            end
            OP_JZ:   if (acc == 8'h00) nxt = tgt;
            OP_JNZ:  if (acc != 8'h00) nxt = tgt;
            OP_LJMP: nxt = code_addr_t'({b1, b2});
            default: ;
         endcase
         pc = nxt;
         steps++;
      end
   endfunction

   //////////////////////////////////////////////////
   // frame monitor, mid-bit sampling

   task automatic receive_frame(output code_byte_t data, output int status);
      int cycles;
      int i;
      status = RX_OK;
      data   = 8'h00;
      cycles = 0;
      while (i_tx && cycles < BYTE_TIMEOUT) begin
         @(posedge i_clk);
         cycles++;
      end
      if (i_tx) begin
         status = RX_TIMEOUT;
      end else begin
         repeat (BIT / 2) @(posedge i_clk);
         if (i_tx) status = RX_FRAMING;        // start bit gone at its middle
         for (i = 0; i < 8; i++) begin
            repeat (BIT) @(posedge i_clk);
            data[i] = i_tx;                    // lsb first
         end
         repeat (BIT) @(posedge i_clk);
         if (!i_tx) status = RX_FRAMING;
      end
   endtask

   task automatic run_test();
      int         cycles;
      int         idx;
      int         errs;
      int         status;
      code_byte_t got;
      build_expected(i_image);
      errs   = 0;
      status = RX_OK;
      cycles = 0;
      // line must idle high through the whole load
      while (i_loading && cycles < LOAD_TIMEOUT) begin
         if (!i_tx && errs == 0) begin
            $display("test %0d: tx line went low while the program was loading", i_test_id);
            errs++;
         end
         @(posedge i_clk);
         cycles++;
      end
      if (i_loading) begin
         $display("test %0d: load phase never ended", i_test_id);
         errs++;
      end
      idx = 0;
      while (idx < expect_q.size() && status != RX_TIMEOUT) begin
         receive_frame(got, status);
         if (status == RX_TIMEOUT) begin
            $display("test %0d: timeout, byte %0d of %0d never arrived", i_test_id, idx,
                     expect_q.size());
            errs++;
         end else begin
            if (status == RX_FRAMING) begin
               $display("test %0d: frame %0d has a bad start or stop bit", i_test_id, idx);
               errs++;
            end
            if (got !== expect_q[idx]) begin
               $display("CHECK FAILED at %0t: test %0d byte %0d expected %02h got %02h",
                        $time, i_test_id, idx, expect_q[idx], got);
               errs++;
            end
            idx++;
         end
      end
      // anything after the last expected byte is extra
      if (status != RX_TIMEOUT) begin
         cycles = 0;
         while (i_tx && cycles < QUIET_CYCLES) begin
            @(posedge i_clk);
            cycles++;
         end
         if (!i_tx) begin
            receive_frame(got, status);
            $display("test %0d: unexpected extra byte %02h on tx", i_test_id, got);
            errs++;
         end
      end
      if (errs == 0) begin
         $display("test %0d passed, %0d bytes matched", i_test_id, expect_q.size());
      end else begin
         $display("test %0d failed with %0d errors", i_test_id, errs);
         o_tests_failed <= o_tests_failed + 1;
      end
      o_tests_done <= o_tests_done + 1;
   endtask

   initial begin
      o_tests_done   <= 0;
      o_tests_failed <= 0;
      forever begin
         @(posedge i_clk);
         if (i_loading) run_test();
      end
   end

endmodule

`default_nettype wire

// ==== verification/ice51_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "ice51_macros.svh"

module ice51_tb import ice51_pkg::*; ();

   localparam int BIT          = `ICE51_BAUD_DIV;
   localparam int DONE_TIMEOUT = 300 * 10 * BIT;
   localparam int NUM_TESTS    = 4;

   logic       clk;
   logic       nrst;
   logic       uart_rx;
   wire        uart_tx;
   logic       loading;
   logic [7:0] test_id;
   code_byte_t image [128];
   code_byte_t prog [$];
   int         tests_done;
   int         tests_failed;
   int         timeouts;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ice51_top dut0 (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (uart_rx),
      .o_uart_tx (uart_tx)
   );

   ice51_checker chk0 (
      .i_clk          (clk),
      .i_tx           (uart_tx),
      .i_loading      (loading),
      .i_test_id      (test_id),
      .i_image        (image),
      .o_tests_done   (tests_done),
      .o_tests_failed (tests_failed)
   );

   //////////////////////////////////////////////////
   // program building and serial load

   task automatic emit(input int n, input code_byte_t b0, input code_byte_t b1,
                       input code_byte_t b2);
      prog.push_back(b0);
      if (n > 1) prog.push_back(b1);
      if (n > 2) prog.push_back(b2);
   endtask

   task automatic send_byte(input code_byte_t b);
      logic [9:0] frame;
      int         i;
      frame = {1'b1, b, 1'b0};              // stop, data, start
      for (i = 0; i < 10; i++) begin
         @(posedge clk);
         uart_rx <= frame[i];
         repeat (BIT - 1) @(posedge clk);
      end
   endtask

   task automatic run_program(input logic [7:0] id);
      int i;
      int start_count;
      int cycles;
      for (i = 0; i < 128; i++) image[i] = 8'h00;
      for (i = 0; i < prog.size(); i++) image[`ICE51_RESET_PC + i] = prog[i];
      image[`ICE51_RESET_PC + prog.size()]     = 8'h80;   // sjmp $
      image[`ICE51_RESET_PC + prog.size() + 1] = 8'hFE;
      prog.delete();
      @(posedge clk);
      nrst <= 1'b0;
      repeat (16) @(posedge clk);
      nrst    <= 1'b1;
      test_id <= id;
      loading <= 1'b1;
      start_count = tests_done;
      for (i = 0; i < 128; i++) send_byte(image[i]);
      @(posedge clk);
      loading <= 1'b0;
      cycles = 0;
      while (tests_done == start_count && cycles < DONE_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (tests_done == start_count) begin
         $display("test %0d timed out waiting for the checker", id);
         timeouts++;
      end
   endtask

   //////////////////////////////////////////////////
   // tests

   initial begin
      nrst    <= 1'b0;
      uart_rx <= 1'b1;
      loading <= 1'b0;
      test_id <= 8'd0;
      timeouts = 0;
      void'($urandom(32'h6d27));

      // accumulator ops with random immediates
      emit(3, 8'h90, 8'h02, 8'h01);
      emit(2, 8'h74, code_byte_t'($urandom), 8'h00);
      emit(1, 8'hF0, 8'h00, 8'h00);
      emit(2, 8'h24, code_byte_t'($urandom), 8'h00);
      emit(1, 8'hF0, 8'h00, 8'h00);
      emit(2, 8'h64, code_byte_t'($urandom), 8'h00);
      emit(1, 8'hF0, 8'h00, 8'h00);
      emit(1, 8'h14, 8'h00, 8'h00);
      emit(1, 8'hF0, 8'h00, 8'h00);
      emit(1, 8'hE4, 8'h00, 8'h00);
      emit(1, 8'hF0, 8'h00, 8'h00);
      emit(1, 8'h14, 8'h00, 8'h00);          // 00 -> ff
      emit(1, 8'hF0, 8'h00, 8'h00);
      emit(2, 8'h24, code_byte_t'($urandom), 8'h00);
      emit(1, 8'hF0, 8'h00, 8'h00);
      run_program(8'd1);

      // control flow with addresses in the comments
      if (timeouts == 0) begin
         emit(3, 8'h90, 8'h02, 8'h01);       // 03
         emit(3, 8'h02, 8'h00, 8'h0E);       // 06 ljmp 0e
         emit(2, 8'h74, 8'hEE, 8'h00);       // 09 reached by the sjmp back
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(2, 8'h80, 8'hFE, 8'h00);       // 0c sjmp $
         emit(2, 8'h74, 8'h03, 8'h00);       // 0e
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(1, 8'h14, 8'h00, 8'h00);       // 11 countdown loop
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(2, 8'h70, 8'hFC, 8'h00);       // 13 jnz 11
         emit(2, 8'h60, 8'h02, 8'h00);       // 15 jz taken
         emit(2, 8'h74, 8'h77, 8'h00);
         emit(2, 8'h24, 8'h09, 8'h00);       // 19
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(2, 8'h60, 8'h05, 8'h00);       // jz not taken
         emit(2, 8'h70, 8'h02, 8'h00);       // jnz taken
         emit(2, 8'h74, 8'h66, 8'h00);
         emit(2, 8'h64, 8'h09, 8'h00);
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(2, 8'h70, 8'h10, 8'h00);       // jnz not taken
         emit(2, 8'h80, 8'h03, 8'h00);       // 27 sjmp forward to 2c
         emit(2, 8'h74, 8'h55, 8'h00);       // 29 skipped
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(2, 8'h80, 8'hDB, 8'h00);       // 2c sjmp back to 09
         run_program(8'd2);
      end

      // back-to-back transmits against one credit
      if (timeouts == 0) begin
         emit(3, 8'h90, 8'h02, 8'h01);
         emit(2, 8'h74, 8'h5A, 8'h00);
         repeat (5) emit(1, 8'hF0, 8'h00, 8'h00);
         emit(2, 8'h24, 8'h01, 8'h00);
         emit(1, 8'hF0, 8'h00, 8'h00);
         run_program(8'd3);
      end

      // movx elsewhere is silent and a5 runs as nop
      if (timeouts == 0) begin
         emit(3, 8'h90, 8'h12, 8'h34);
         emit(2, 8'h74, 8'h11, 8'h00);
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(1, 8'hA5, 8'h00, 8'h00);
         emit(3, 8'h90, 8'h02, 8'h01);
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(3, 8'h90, 8'h02, 8'h00);
         emit(2, 8'h24, 8'h01, 8'h00);
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(3, 8'h90, 8'h03, 8'h01);
         emit(1, 8'hF0, 8'h00, 8'h00);
         emit(3, 8'h90, 8'h02, 8'h01);
         emit(1, 8'hF0, 8'h00, 8'h00);
         run_program(8'd4);
      end

      $display("tests run %0d, failed %0d, timed out %0d", tests_done, tests_failed, timeouts);
      if ((tests_failed == 0) && (timeouts == 0) && (tests_done == NUM_TESTS)) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hdl/ice51_pkg.sv
hdl/baud_timer.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/code_store.sv
hdl/cpu_sequencer.sv
hdl/cpu_datapath.sv
hdl/ice51_top.sv
verification/ice51_checker.sv
verification/ice51_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ice51 testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps \
   -f build.f --top-module ice51_tb -o ice51_sim

./obj_dir/ice51_sim > sim.log
cat sim.log

if grep -q "^Everything OK$" sim.log; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi
